// File: rtl/eeprom_bit_engine.sv
`timescale 1ns/1ps
module eeprom_bit_engine #(
    parameter int SCL_HALF = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                op_go,
    input  eeprom_pkg::bus_op_t op,
    input  eeprom_pkg::byte_t   op_byte,
    input  logic                sda_in,
    output logic                scl,
    output logic                sda_low,
    output logic                op_done,
    output eeprom_pkg::byte_t   rx_byte
);
    import eeprom_pkg::*;

    localparam int CW  = $clog2(SCL_HALF);
    localparam int MID = SCL_HALF / 2;

    logic          busy;
    bus_op_t       cur_op;
    logic [CW-1:0] cnt;
    logic [4:0]    half;        // odd halves are the scl high phase
    byte_t         shreg;
    logic          half_end;
    logic          last_half;
    logic          at_mid;
    logic          low_part;
    logic          ack_slot;

    assign half_end  = (cnt == CW'(SCL_HALF - 1));
    assign at_mid    = (cnt == CW'(MID));
    assign low_part  = (cnt < CW'(MID));
    assign ack_slot  = half[4];  // halves 16 and 17
    assign last_half = (cur_op == op_start || cur_op == op_stop) ? (half == 5'd1)
                                                                 : (half == 5'd17);
    assign rx_byte   = shreg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            cnt     <= '0;
            half    <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (op_go)
                begin
                    busy <= 1'b1;
                    cnt  <= '0;
                    half <= '0;
                end
            end
            else
            begin
                scl <= half[0];
                cnt <= half_end ? '0 : cnt + 1'b1;
                if (half_end)
                begin
                    if (last_half)
                    begin
                        busy    <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                        half <= half + 5'd1;
                end
                case (cur_op)
                    op_start:
                        sda_low <= half[0] && !low_part;   // falls mid high phase
                    op_stop:
                        if (half[0])
                            sda_low <= low_part;           // rises mid high phase
                        else if (!low_part)
                            sda_low <= 1'b1;
                    op_write:
                        if (!half[0] && at_mid)
                            sda_low <= !ack_slot && !shreg[7];
                    default:
                        if (!half[0] && at_mid)
                            sda_low <= 1'b0;               // no ack after the read byte
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && op_go)
        begin
            cur_op <= op;
            if (op == op_write)
                shreg <= op_byte;
        end
        else if (busy && cur_op == op_write && !half[0] && at_mid)
            shreg <= {shreg[6:0], 1'b0};                   // msb first
        else if (busy && cur_op == op_read && half[0] && cnt == '0 && !ack_slot)
            shreg <= {shreg[6:0], sda_in};                 // sampled as scl rises
    end

endmodule

// File: rtl/eeprom_frame_seq.sv
`timescale 1ns/1ps
module eeprom_frame_seq (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  logic                cmd_read,
    input  eeprom_pkg::addr_t   cmd_addr,
    input  eeprom_pkg::byte_t   cmd_data,
    input  logic                op_done,
    input  eeprom_pkg::byte_t   rx_byte,
    output logic                cmd_take,
    output logic                op_go,
    output eeprom_pkg::bus_op_t op,
    output eeprom_pkg::byte_t   op_byte,
    output eeprom_pkg::byte_t   rdata,
    output logic                ack
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_ctrl,
        s_addr_lo,
        s_data,
        s_restart,
        s_ctrl_rd,
        s_read,
        s_stop,
        s_done
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   rd_q;
    addr_t  addr_q;
    byte_t  data_q;
    logic   fire;

    assign cmd_take = (state == s_idle) && cmd_valid;
    assign ack      = (state == s_done);

    // every step into a bus state sends one operation
    assign fire = (state_nxt != state) && (state_nxt != s_idle) && (state_nxt != s_done);

    always_comb
    begin
        state_nxt = state;
        case (state)
            s_idle:    if (cmd_valid) state_nxt = s_start;
            s_start:   if (op_done) state_nxt = s_ctrl;
            s_ctrl:    if (op_done) state_nxt = s_addr_lo;
            s_addr_lo: if (op_done) state_nxt = rd_q ? s_restart : s_data;
            s_data:    if (op_done) state_nxt = s_stop;
            s_restart: if (op_done) state_nxt = s_ctrl_rd;
            s_ctrl_rd: if (op_done) state_nxt = s_read;
            s_read:    if (op_done) state_nxt = s_stop;
            s_stop:    if (op_done) state_nxt = s_done;
            default:   state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= s_idle;
            op_go <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            op_go <= fire;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_take)
        begin
            rd_q   <= cmd_read;
            addr_q <= cmd_addr;
            data_q <= cmd_data;
        end
        if (fire)
        begin
            case (state_nxt)
                s_start, s_restart: op <= op_start;
                s_read:             op <= op_read;
                s_stop:             op <= op_stop;
                default:            op <= op_write;
            endcase
            case (state_nxt)
                s_ctrl:    op_byte <= {DEV_TAG, addr_q[10:8], 1'b0};   // dummy write first
                s_ctrl_rd: op_byte <= {DEV_TAG, addr_q[10:8], 1'b1};
                s_addr_lo: op_byte <= addr_q[7:0];
                default:   op_byte <= data_q;
            endcase
        end
        // rx_byte still holds the read byte once the stop is done
        if (state_nxt == s_done && rd_q)
            rdata <= rx_byte;
    end

endmodule

// File: rtl/eeprom_master_top.sv
`timescale 1ns/1ps
module eeprom_master_top #(
    parameter int SCL_HALF = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::byte_t wdata,
    output eeprom_pkg::byte_t rdata,
    output logic              ack,
    output logic              busy,
    output logic              scl,
    inout  wire               sda
);
    import eeprom_pkg::*;

    logic    cmd_valid;
    logic    cmd_read;
    addr_t   cmd_addr;
    byte_t   cmd_data;
    logic    cmd_take;
    logic    op_go;
    bus_op_t op;
    byte_t   op_byte;
    logic    op_done;
    byte_t   rx_byte;
    logic    sda_low;
    logic    sda_in;

    // open drain, pull-up sits outside
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_req_stage u_req (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_take  (cmd_take),
        .cmd_valid (cmd_valid),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .busy      (busy)
    );

    eeprom_frame_seq u_seq (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .cmd_take  (cmd_take),
        .op_go     (op_go),
        .op        (op),
        .op_byte   (op_byte),
        .rdata     (rdata),
        .ack       (ack)
    );

    eeprom_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) u_bit (
        .clk       (clk),
        .reset     (reset),
        .op_go     (op_go),
        .op        (op),
        .op_byte   (op_byte),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_low   (sda_low),
        .op_done   (op_done),
        .rx_byte   (rx_byte)
    );

endmodule

// File: rtl/eeprom_pkg.sv
package eeprom_pkg;

    // 2 K-byte part, 11 address bits
    typedef logic [10:0] addr_t;
    typedef logic [7:0]  byte_t;

    // operations handed from the frame sequencer to the bit engine
    typedef enum logic [1:0] {
        op_start,   // repeated start when issued after a byte
        op_write,
        op_read,
        op_stop
    } bus_op_t;

    // device type code, upper nibble of every control byte
    localparam logic [3:0] DEV_TAG = 4'b1010;

endpackage

// File: rtl/eeprom_req_stage.sv
`timescale 1ns/1ps
module eeprom_req_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::byte_t wdata,
    input  logic              cmd_take,
    output logic              cmd_valid,
    output logic              cmd_read,
    output eeprom_pkg::addr_t cmd_addr,
    output eeprom_pkg::byte_t cmd_data,
    output logic              busy
);
    import eeprom_pkg::*;

    logic  pend_valid;
    logic  pend_read;
    addr_t pend_addr;
    byte_t pend_data;
    logic  accept;

    assign busy   = cmd_valid & pend_valid;
    assign accept = (wr | rd) & ~busy;     // dropped while both slots are full

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmd_valid  <= 1'b0;
            pend_valid <= 1'b0;
        end
        else if (cmd_take)
        begin
            cmd_valid  <= pend_valid | accept;
            pend_valid <= 1'b0;
        end
        else if (accept)
        begin
            if (!cmd_valid)
                cmd_valid <= 1'b1;
            else
                pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_take && pend_valid)
        begin
            cmd_read <= pend_read;       // promote pending entry
            cmd_addr <= pend_addr;
            cmd_data <= pend_data;
        end
        else if (accept && (cmd_take || !cmd_valid))
        begin
            cmd_read <= ~wr;             // wr wins over rd
            cmd_addr <= addr;
            cmd_data <= wdata;
        end
        if (accept && cmd_valid && !cmd_take)
        begin
            pend_read <= ~wr;
            pend_addr <= addr;
            pend_data <= wdata;
        end
    end

endmodule

// File: sim.f
rtl/eeprom_pkg.sv
rtl/eeprom_req_stage.sv
rtl/eeprom_frame_seq.sv
rtl/eeprom_bit_engine.sv
rtl/eeprom_master_top.sv
verif/eeprom_model.sv
verif/eeprom_master_assert.sv
verif/tb_eeprom_master.sv

// File: verif/eeprom_master_assert.sv
`timescale 1ns/1ps
module eeprom_master_assert (
    input  logic                clk,
    input  logic                reset,
    input  logic                scl,
    input  logic                sda,
    input  logic                ack,
    input  logic                busy,
    input  eeprom_pkg::bus_op_t op
);
    import eeprom_pkg::*;

    int fail_cnt = 0;   // failed assertions so far

    // only start and stop may move sda during the high phase
    sda_stable: assert property (@(posedge clk) disable iff (reset)
        (scl && $past(scl) && op != op_start && op != op_stop) |-> $stable(sda))
        else
        begin
            fail_cnt++;
            $error("sda changed while scl was high outside start/stop");
        end

    ack_pulse: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else
        begin
            fail_cnt++;
            $error("ack held longer than one cycle");
        end

    busy_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy ##1 !busy)
        else
        begin
            fail_cnt++;
            $error("busy high right after reset release");
        end

endmodule

bind eeprom_master_top eeprom_master_assert u_assert (
    .clk   (clk),
    .reset (reset),
    .scl   (scl),
    .sda   (sda),
    .ack   (ack),
    .busy  (busy),
    .op    (op)
);

// File: verif/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
    input  logic scl,
    inout  wire  sda
);
    import eeprom_pkg::*;

    byte_t mem [0:2047];
    logic  drive_low;
    addr_t ptr;
    byte_t ctrl;
    byte_t lo;
    byte_t b;
    logic  restart;

    assign sda = drive_low ? 1'b0 : 1'bz;

    task automatic wait_start();
        do @(negedge sda); while (scl !== 1'b1);
    endtask

    task automatic wait_stop();
        do @(posedge sda); while (scl !== 1'b1);
    endtask

    // returns at the scl fall after the last bit, or early on a repeated start
    task automatic recv_byte(output byte_t v, output logic rs);
        logic bit_v;
        rs = 1'b0;
        v  = '0;
        for (int i = 0; i < 8 && !rs; i++)
        begin
            @(posedge scl);
            bit_v = sda;
            v     = {v[6:0], bit_v};
            while (scl === 1'b1 && !rs)
            begin
                @(scl or sda);
                if (scl === 1'b1 && bit_v && sda === 1'b0)
                    rs = 1'b1;     // sda fell with scl high
            end
        end
    endtask

    task automatic send_ack();
        drive_low = 1'b1;
        @(negedge scl);
        drive_low = 1'b0;
    endtask

    task automatic send_byte(input byte_t v);
        for (int i = 7; i >= 0; i--)
        begin
            drive_low = !v[i];
            @(negedge scl);
        end
        drive_low = 1'b0;              // master nacks in the ninth slot
    endtask

    initial
    begin
        drive_low = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        forever
        begin
            wait_start();
            recv_byte(ctrl, restart);
            send_ack();
            recv_byte(lo, restart);
            send_ack();
            ptr = {ctrl[3:1], lo};
            recv_byte(b, restart);
            if (restart)
            begin
                recv_byte(ctrl, restart);  // read control byte
                send_ack();
                send_byte(mem[ptr]);
            end
            else
            begin
                send_ack();
                mem[ptr] = b;
            end
            wait_stop();
        end
    end

endmodule

// File: verif/tb_eeprom_master.sv
`timescale 1ns/1ps
module tb_eeprom_master;
    import eeprom_pkg::*;

    localparam int SCL_HALF = 2;
    localparam int N_RAND   = 60;
    localparam int N_REQ    = N_RAND + 8;
    localparam int LIMIT    = 2 * N_REQ * (100 * SCL_HALF + 10);

    typedef struct packed {
        logic  read;
        addr_t addr;
        byte_t data;
    } req_t;

    logic  clk;
    logic  reset;
    logic  wr;
    logic  rd;
    addr_t addr;
    byte_t wdata;
    byte_t rdata;
    logic  ack;
    logic  busy;
    logic  scl;
    wire   sda;

    byte_t ref_mem [0:2047];
    req_t  pending[$];
    int    accepted;
    int    acks;
    int    val_errors;
    int    other_errors;
    logic  acc;

    pullup (sda);

    eeprom_master_top #(.SCL_HALF(SCL_HALF)) dut (
        .clk(clk), .reset(reset), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .busy(busy), .scl(scl), .sda(sda)
    );

    eeprom_model u_mem (.scl(scl), .sda(sda));

    function automatic byte_t exp_read(input addr_t a);
        return ref_mem[a];
    endfunction

    task automatic issue(input logic read, input addr_t a, input byte_t d, output logic ok);
        @(negedge clk);
        wr    = !read;
        rd    = read;
        addr  = a;
        wdata = d;
        ok    = !busy;                 // dropped when both slots are full
        if (ok)
        begin
            pending.push_back({read, a, d});
            accepted++;
        end
        @(negedge clk);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending.size() != 0)
            @(posedge clk);
    endtask

    task automatic issue_when_free(input logic read, input addr_t a, input byte_t d);
        logic ok;
        while (busy)
            @(negedge clk);
        issue(read, a, d, ok);
    endtask

    // requests complete in order, so the mirror is updated at ack time
    always @(posedge clk)
    begin
        req_t r;
        if (!reset && ack)
        begin
            acks++;
            if (pending.size() == 0)
            begin
                other_errors++;
                $display("ack seen with no outstanding request at %0t", $time);
            end
            else
            begin
                r = pending.pop_front();
                if (r.read)
                    assert (rdata == exp_read(r.addr))
                    else
                    begin
                        val_errors++;
                        $display("[FAIL] %0t: addr %h read %h expected %h",
                                 $time, r.addr, rdata, exp_read(r.addr));
                    end
                else
                    ref_mem[r.addr] = r.data;
            end
        end
    end

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        repeat (LIMIT) @(posedge clk);
        $display("run hung: requests still outstanding after %0d cycles", LIMIT);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        void'($urandom(94182));
        reset = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hFF;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (scl === 1'b1 && sda === 1'b1 && ack === 1'b0 && busy === 1'b0)
        else
        begin
            val_errors++;
            $display("[FAIL] %0t: idle bus state wrong after reset", $time);
        end

        // write then read back, then a never written byte
        issue(1'b0, 11'h123, 8'h5A, acc);
        issue(1'b1, 11'h123, 8'h00, acc);
        issue_when_free(1'b1, 11'h7FE, 8'h00);
        wait_idle();

        for (int i = 0; i < N_RAND; i++)
            issue_when_free(1'($urandom_range(0, 1)), {i[2:0], 8'($urandom_range(0, 7))},
                            8'($urandom));
        wait_idle();

        // two strobes queue behind a frame and fill the buffer, the next one bounces
        issue(1'b0, 11'h2C4, 8'hA7, acc);
        @(negedge scl);
        issue(1'b1, 11'h2C4, 8'h00, acc);
        assert (acc)
        else
        begin
            other_errors++;
            $display("queued request was refused while a frame was on the bus");
        end
        issue(1'b0, 11'h2C5, 8'h69, acc);
        issue(1'b0, 11'h555, 8'h3C, acc);
        assert (!acc)
        else
        begin
            other_errors++;
            $display("request accepted although busy was high");
        end
        wait_idle();
        issue(1'b1, 11'h555, 8'h00, acc);
        wait_idle();
        repeat (20) @(posedge clk);

        assert (acks == accepted)
        else
        begin
            other_errors++;
            $display("ack count %0d differs from %0d accepted requests", acks, accepted);
        end
        $display("errors: %0d value, %0d other, %0d assertion", val_errors, other_errors,
                 dut.u_assert.fail_cnt);
        if (val_errors == 0 && other_errors == 0 && dut.u_assert.fail_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
